//--- logic/gfx_pkg.sv
package gfx_pkg;

  // Width of one stored pixel word.
  localparam int pixel_bits = 12;

  // Each colour field takes an equal share of the pixel word.
  localparam int chan_bits = pixel_bits / 3;

  typedef struct packed {
    logic [chan_bits-1:0] red;    // Most significant field.
    logic [chan_bits-1:0] green;
    logic [chan_bits-1:0] blue;   // Least significant field.
  } gfx_rgb_t;

  // The pattern stage builds colours field by field, while the memory
  // only ever sees the flat word.
  typedef union packed {
    logic [pixel_bits-1:0] raw;   // Storage view.
    gfx_rgb_t              rgb;   // Per-channel view.
  } gfx_color_u;

  // One pixel with its screen coordinates, as carried through the queue.
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    gfx_color_u  color;
  } gfx_pixel_t;

  // Write request from the queue into the frame buffer.
  typedef struct packed {
    logic       valid;
    gfx_pixel_t pixel;
  } gfx_fb_wr_t;

  // Fill controller states.
  typedef enum logic [1:0] {
    idle,
    fill,
    drain
  } gfx_fill_state_t;

endpackage

//--- logic/gfx_fill_ctrl.sv
`timescale 1ns/1ps

module gfx_fill_ctrl #(
  parameter int queue_depth = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic last,
  input  logic credit_return,
  output logic step,
  output logic busy,
  output logic done
);

  import gfx_pkg::*;

  localparam int credit_bits = $clog2(queue_depth + 1);

  gfx_fill_state_t        state;
  logic [credit_bits-1:0] credits;        // Free queue slots seen from this side.

  // A step spends one credit, so it is only issued while one is held.
  assign step = (state == fill) && (credits != '0);
  assign busy = (state != idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      credits <= credit_bits'(queue_depth);
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= fill;
          end
        end
        fill: begin
          // Leaving fill on the final step stops any further stepping.
          if (step && last) begin
            state <= drain;
          end
        end
        drain: begin
          // All credits home means every pixel reached memory.
          if (credits == credit_bits'(queue_depth)) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: state <= idle;
      endcase

      // A spend and a return in the same cycle cancel out.
      if (step && !credit_return) begin
        credits <= credits - 1'b1;
      end else if (!step && credit_return) begin
        credits <= credits + 1'b1;
      end
    end
  end

endmodule

//--- logic/gfx_raster_counter.sv
`timescale 1ns/1ps

module gfx_raster_counter #(
  parameter int fb_width  = 24,
  parameter int fb_height = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  output logic [15:0] x,
  output logic [15:0] y,
  output logic        last
);

  localparam logic [15:0] max_x = 16'(fb_width - 1);
  localparam logic [15:0] max_y = 16'(fb_height - 1);

  logic end_of_line;

  assign end_of_line = (x == max_x);
  assign last        = end_of_line && (y == max_y);   // Bottom right pixel.

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (step) begin
      if (end_of_line) begin
        x <= '0;
        // Wrap to the top after the final row.
        if (y == max_y) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

//--- logic/gfx_test_pattern.sv
`timescale 1ns/1ps

module gfx_test_pattern #(
  parameter int fb_width = 24
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               step,
  input  logic [15:0]        x,
  input  logic [15:0]        y,
  output gfx_pkg::gfx_pixel_t pixel,
  output logic               pix_valid
);

  import gfx_pkg::*;

  // Bar edges at one and two thirds of the line.
  localparam logic [15:0] green_start = 16'(fb_width / 3);
  localparam logic [15:0] blue_start  = 16'((2 * fb_width) / 3);

  localparam logic [chan_bits-1:0] chan_on = '1;

  gfx_color_u bar_color;

  always_comb begin
    bar_color.raw = '0;
    if (x < green_start) begin
      bar_color.rgb.red = chan_on;
    end else if (x < blue_start) begin
      bar_color.rgb.green = chan_on;
    end else begin
      bar_color.rgb.blue = chan_on;
    end
  end

  // Pixel payload is captured alongside the counter advance.
  always_ff @(posedge clk) begin
    if (step) begin
      pixel.x     <= x;
      pixel.y     <= y;
      pixel.color <= bar_color;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= step;   // One pulse per stepped pixel.
    end
  end

endmodule

//--- logic/gfx_write_queue.sv
`timescale 1ns/1ps

module gfx_write_queue #(
  parameter int queue_depth = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  gfx_pkg::gfx_pixel_t push_pixel,
  input  logic                rd_en,
  output logic                fb_wr_valid,
  output gfx_pkg::gfx_pixel_t fb_wr_pixel,
  output logic                credit_return
);

  import gfx_pkg::*;

  localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int count_bits = $clog2(queue_depth + 1);
  localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(queue_depth - 1);

  gfx_pixel_t            slots [queue_depth];
  logic [ptr_bits-1:0]   wr_ptr;
  logic [ptr_bits-1:0]   rd_ptr;
  logic [count_bits-1:0] count;
  logic                  pop;

  // External reads own the memory port, so draining waits for them.
  assign pop           = (count != '0) && !rd_en;
  assign fb_wr_valid   = pop;
  assign fb_wr_pixel   = slots[rd_ptr];
  assign credit_return = pop;   // Each drained entry frees a slot.

  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= push_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- logic/gfx_framebuffer.sv
`timescale 1ns/1ps

module gfx_framebuffer #(
  parameter int fb_width  = 24,
  parameter int fb_height = 8
) (
  input  logic                clk,
  input  logic                wr_valid,
  input  gfx_pkg::gfx_pixel_t wr_pixel,
  input  logic                rd_en,
  input  logic [15:0]         rd_x,
  input  logic [15:0]         rd_y,
  output gfx_pkg::gfx_color_u rd_data
);

  import gfx_pkg::*;

  localparam int depth     = fb_width * fb_height;
  localparam int addr_bits = (depth > 1) ? $clog2(depth) : 1;

  logic [pixel_bits-1:0] mem [depth];
  logic [addr_bits-1:0]  wr_addr;
  logic [addr_bits-1:0]  rd_addr;

  // Row-major layout, one word per pixel.
  assign wr_addr = addr_bits'(wr_pixel.y * fb_width + wr_pixel.x);
  assign rd_addr = addr_bits'(rd_y * fb_width + rd_x);

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_pixel.color.raw;
    end
  end

  // Read data appears the cycle after the request.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data.raw <= mem[rd_addr];
    end
  end

endmodule

//--- logic/gfx_fill_top.sv
`timescale 1ns/1ps

module gfx_fill_top #(
  parameter int fb_width    = 24,
  parameter int fb_height   = 8,
  parameter int queue_depth = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                rd_en,
  input  logic [15:0]         rd_x,
  input  logic [15:0]         rd_y,
  output gfx_pkg::gfx_color_u rd_data,
  output logic                busy,
  output logic                done
);

  import gfx_pkg::*;

  logic        step;
  logic        last;
  logic        credit_return;
  logic [15:0] x;
  logic [15:0] y;
  gfx_pixel_t  pixel;
  logic        pix_valid;
  gfx_fb_wr_t  fb_wr;   // Queue output into memory.

  gfx_fill_ctrl #(.queue_depth(queue_depth)) u_ctrl (
    .clk(clk), .reset(reset), .start(start), .last(last),
    .credit_return(credit_return), .step(step), .busy(busy), .done(done)
  );

  gfx_raster_counter #(.fb_width(fb_width), .fb_height(fb_height)) u_counter (
    .clk(clk), .reset(reset), .step(step), .x(x), .y(y), .last(last)
  );

  gfx_test_pattern #(.fb_width(fb_width)) u_pattern (
    .clk(clk), .reset(reset), .step(step), .x(x), .y(y),
    .pixel(pixel), .pix_valid(pix_valid)
  );

  gfx_write_queue #(.queue_depth(queue_depth)) u_queue (
    .clk(clk), .reset(reset), .push(pix_valid), .push_pixel(pixel), .rd_en(rd_en),
    .fb_wr_valid(fb_wr.valid), .fb_wr_pixel(fb_wr.pixel),
    .credit_return(credit_return)
  );

  gfx_framebuffer #(.fb_width(fb_width), .fb_height(fb_height)) u_fb (
    .clk(clk), .wr_valid(fb_wr.valid), .wr_pixel(fb_wr.pixel),
    .rd_en(rd_en), .rd_x(rd_x), .rd_y(rd_y), .rd_data(rd_data)
  );

endmodule

//--- bench/gfx_fill_tb.sv
`timescale 1ns/1ps

module gfx_fill_tb;

  import gfx_pkg::*;

  localparam int fb_width     = 24;     // Matches the DUT defaults.
  localparam int fb_height    = 8;
  localparam int fill_timeout = 5000;   // Cycles allowed for one fill.

  logic        clk;
  logic        reset;
  logic        start;
  logic        rd_en;
  logic [15:0] rd_x;
  logic [15:0] rd_y;
  gfx_color_u  rd_data;
  logic        busy;
  logic        done;
  int          done_count;

  gfx_fill_top DUT (
    .clk(clk), .reset(reset), .start(start), .rd_en(rd_en), .rd_x(rd_x), .rd_y(rd_y),
    .rd_data(rd_data), .busy(busy), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      done_count <= 0;
    end else if (done) begin
      done_count <= done_count + 1;   // Every done pulse is counted.
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  assert property (@(posedge clk) disable iff (reset) done |-> (!busy && $past(busy)))
    else stop_on_error($sformatf("At %0t busy did not fall together with done", $time));
  assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else stop_on_error($sformatf("At %0t done stayed high for two cycles", $time));
  assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
    else stop_on_error($sformatf("At %0t busy did not rise after start", $time));

  // Three equal bars, red on the left and blue on the right.
  function automatic gfx_rgb_t golden_bar(input int px);
    gfx_rgb_t c;
    c = '0;
    if (px < fb_width / 3) begin
      c.red = '1;
    end else if (px < (2 * fb_width) / 3) begin
      c.green = '1;
    end else begin
      c.blue = '1;
    end
    return c;
  endfunction

  task automatic compare_rgb(input int px, input int py);
    gfx_rgb_t want;
    want = golden_bar(px);
    assert (rd_data.rgb.red == want.red) else stop_on_error($sformatf(
      "Mismatch at %0t: rd_data.rgb.red (%0d,%0d) expected %h got %h",
      $time, px, py, want.red, rd_data.rgb.red));
    assert (rd_data.rgb.green == want.green) else stop_on_error($sformatf(
      "Mismatch at %0t: rd_data.rgb.green (%0d,%0d) expected %h got %h",
      $time, px, py, want.green, rd_data.rgb.green));
    assert (rd_data.rgb.blue == want.blue) else stop_on_error($sformatf(
      "Mismatch at %0t: rd_data.rgb.blue (%0d,%0d) expected %h got %h",
      $time, px, py, want.blue, rd_data.rgb.blue));
  endtask

  task automatic read_frame();
    for (int py = 0; py < fb_height; py++) begin
      for (int px = 0; px < fb_width; px++) begin
        rd_en = 1'b1;
        rd_x  = 16'(px);
        rd_y  = 16'(py);
        @(negedge clk);
        rd_en = 1'b0;
        compare_rgb(px, py);   // Data is registered one cycle after rd_en.
      end
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    assert (busy) else stop_on_error($sformatf(
      "Mismatch at %0t: busy expected 1 got %b", $time, busy));
  endtask

  // Optional mode pokes start while busy; the DUT must ignore it.
  task automatic run_fill(input bit poke_start);
    int  cycles;
    bit  seen;
    cycles = 0;
    seen   = 1'b0;
    pulse_start();
    while (!seen && cycles < fill_timeout) begin
      @(negedge clk);
      cycles++;
      start = 1'b0;
      if (done) begin
        seen = 1'b1;
      end else if (poke_start && busy && (cycles % 3 == 0)) begin
        start = 1'b1;
      end
    end
    start = 1'b0;
    if (!seen) stop_on_error("Timeout: fill never produced a done pulse");
  endtask

  // Random read bursts hold the memory port and stall the queue.
  task automatic run_fill_with_reads();
    int cycles;
    int burst;
    int gap;
    int last_x;
    int last_y;
    bit seen;
    bit pending;
    cycles  = 0;
    burst   = 0;
    gap     = 0;
    seen    = 1'b0;
    pending = 1'b0;
    pulse_start();
    while (!seen && cycles < fill_timeout) begin
      @(negedge clk);
      cycles++;
      if (pending) compare_rgb(last_x, last_y);   // Frame still holds fill one data.
      pending = 1'b0;
      rd_en   = 1'b0;
      if (done) begin
        seen = 1'b1;
      end else if (burst > 0) begin
        last_x  = $urandom % fb_width;
        last_y  = $urandom % fb_height;
        rd_en   = 1'b1;
        rd_x    = 16'(last_x);
        rd_y    = 16'(last_y);
        pending = 1'b1;
        burst--;
      end else if (gap > 0) begin
        gap--;
      end else begin
        burst = 1 + ($urandom % 8);   // Long enough to use up every credit.
        gap   = $urandom % 6;
      end
    end
    if (!seen) stop_on_error("Timeout: stalled fill never produced a done pulse");
  endtask

  task automatic expect_done_count(input int want);
    repeat (10) @(negedge clk);
    assert (done_count == want) else stop_on_error($sformatf(
      "Mismatch at %0t: done_count expected %0d got %0d", $time, want, done_count));
    assert (!busy) else stop_on_error("Fill restarted after done without a start");
  endtask

  initial begin
    void'($urandom(32'hd86d0be9));
    reset = 1'b1;
    start = 1'b0;
    rd_en = 1'b0;
    rd_x  = '0;
    rd_y  = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    repeat (20) begin
      @(negedge clk);
      assert (!busy && !done) else stop_on_error($sformatf(
        "Mismatch at %0t: busy/done expected 0/0 got %b/%b", $time, busy, done));
    end

    run_fill(1'b0);
    expect_done_count(1);
    read_frame();

    run_fill_with_reads();
    expect_done_count(2);
    read_frame();

    run_fill(1'b1);
    expect_done_count(3);
    read_frame();

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- filelist.f
logic/gfx_pkg.sv
logic/gfx_fill_ctrl.sv
logic/gfx_raster_counter.sv
logic/gfx_test_pattern.sv
logic/gfx_write_queue.sv
logic/gfx_framebuffer.sv
logic/gfx_fill_top.sv
bench/gfx_fill_tb.sv
